// File: common/pbch_params.svh
`ifndef PBCH_PARAMS_SVH
`define PBCH_PARAMS_SVH

// cell identity N_id is 0 to 1007
`define PBCH_NID_W 10

// one DMRS sequence per candidate ibar_SSB
`define PBCH_NUM_IBAR 8

// QPSK pairs kept per sequence, enough for all three PBCH symbols
`define PBCH_DMRS_LEN 144

// Gold sequence LFSR length and the number of bits discarded before c(0)
`define PBCH_GOLD_N 31
`define PBCH_GOLD_NC 1600

// one PBCH symbol spans 240 subcarriers, every fourth one is a pilot
`define PBCH_SC_PER_SYM 240
`define PBCH_PILOTS_PER_SYM 60

// width of one I or Q component
`define PBCH_IQ_W 16

// 60 pilots at up to +-2 each give +-120
`define PBCH_CORR_W 8

`endif

// File: common/pbch_pkg.sv
`include "pbch_params.svh"

package pbch_pkg;

    // im sits in the upper half of the word, re in the lower half
    typedef struct packed {
        logic signed [`PBCH_IQ_W-1:0] im;
        logic signed [`PBCH_IQ_W-1:0] re;
    } iq_sample_t;

    // bit 1 holds c(2m), bit 0 holds c(2m+1)
    typedef logic [1:0] dmrs_pair_t;

    // pair m of every candidate sequence, index is ibar_SSB
    typedef dmrs_pair_t [`PBCH_NUM_IBAR-1:0] dmrs_vec_t;

    typedef logic signed [`PBCH_CORR_W-1:0] corr_sum_t;

    // one correlation sum per candidate
    typedef corr_sum_t [`PBCH_NUM_IBAR-1:0] corr_sums_t;

    // detected candidate and the magnitude of its correlation peak
    typedef struct packed {
        logic [2:0] ibar;
        logic [6:0] peak;
    } ibar_result_t;

endpackage

// File: dmrs_gen/gold_seq_gen.sv
`timescale 1ns/100ps

`include "pbch_params.svh"

module gold_seq_gen #(
    parameter int IBAR = 0
) (
    input  logic                   clk_i,
    input  logic                   reset_ni,
    input  logic                   load_i,
    input  logic [`PBCH_NID_W-1:0] n_id_i,
    output logic                   bit_o
);

    localparam int N = `PBCH_GOLD_N;

    logic [N-1:0] x1_q;
    logic [N-1:0] x2_q;
    logic [N-1:0] seed_hi;
    logic [N-1:0] c_init;

    // c_init = 2^11 (ibar+1)(floor(N_id/4)+1) + 2^6 (ibar+1) + N_id mod 4
    assign seed_hi = N'(IBAR + 1) * (N'(n_id_i[`PBCH_NID_W-1:2]) + N'(1));
    assign c_init  = (seed_hi << 11) + (N'(IBAR + 1) << 6) + N'(n_id_i[1:0]);

    // bit 0 of each register is x(n), so the new bit enters at the top
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            x1_q <= '0;
            x2_q <= '0;
        end else if (load_i) begin
            x1_q <= N'(1);
            x2_q <= c_init;
        end else begin
            // x1(n+31) = x1(n+3) + x1(n)
            x1_q <= {x1_q[3] ^ x1_q[0], x1_q[N-1:1]};
            // x2(n+31) = x2(n+3) + x2(n+2) + x2(n+1) + x2(n)
            x2_q <= {x2_q[3] ^ x2_q[2] ^ x2_q[1] ^ x2_q[0], x2_q[N-1:1]};
        end
    end

    // raw Gold output, the first 1600 bits are dropped by the table FSM
    assign bit_o = x1_q[0] ^ x2_q[0];

endmodule

// File: dmrs_gen/dmrs_table.sv
`timescale 1ns/100ps

`include "pbch_params.svh"

module dmrs_table
    import pbch_pkg::*;
(
    input  logic                                    clk_i,
    input  logic                                    reset_ni,
    input  logic [`PBCH_NID_W-1:0]                  n_id_i,
    input  logic                                    n_id_valid_i,
    output logic                                    n_id_ready_o,
    input  logic [$clog2(`PBCH_PILOTS_PER_SYM)-1:0] pilot_idx_i,
    output dmrs_vec_t                               dmrs_vec_o,
    output logic [1:0]                              pilot_offset_o,
    output logic                                    dmrs_ready_o
);

    localparam int CNT_W = $clog2(`PBCH_GOLD_NC);

    typedef enum logic [1:0] {
        TBL_IDLE,
        TBL_SKIP,
        TBL_STORE,
        TBL_DONE
    } tbl_state_e;

    tbl_state_e                  state_q;
    tbl_state_e                  state_d;
    logic [CNT_W-1:0]            bit_cnt_q;
    logic                        n_id_ready_q;
    logic [1:0]                  offset_q;
    logic                        load;
    logic [`PBCH_NUM_IBAR-1:0]   gen_bits;
    logic [`PBCH_NUM_IBAR-1:0]   even_bits_q;
    dmrs_vec_t                   store_vec;
    dmrs_vec_t                   table_q [`PBCH_DMRS_LEN];

    assign load = n_id_valid_i && n_id_ready_q;

    for (genvar i = 0; i < `PBCH_NUM_IBAR; i++) begin : gen_seq
        gold_seq_gen #(
            .IBAR (i)
        ) gold_i (
            .clk_i    (clk_i),
            .reset_ni (reset_ni),
            .load_i   (load),
            .n_id_i   (n_id_i),
            .bit_o    (gen_bits[i])
        );

        // even bit goes to bit 1 of the pair
        assign store_vec[i] = {even_bits_q[i], gen_bits[i]};
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            TBL_IDLE, TBL_DONE: begin
                if (load) state_d = TBL_SKIP;
            end
            TBL_SKIP: begin
                if (bit_cnt_q == CNT_W'(`PBCH_GOLD_NC - 1)) state_d = TBL_STORE;
            end
            TBL_STORE: begin
                if (bit_cnt_q == CNT_W'(2 * `PBCH_DMRS_LEN - 1)) state_d = TBL_DONE;
            end
            default: state_d = TBL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= TBL_IDLE;
            n_id_ready_q <= 1'b0;
            bit_cnt_q    <= '0;
            offset_q     <= '0;
        end else begin
            state_q      <= state_d;
            // a new N_id may come in before the first one or after the table is complete
            n_id_ready_q <= (state_d == TBL_IDLE) || (state_d == TBL_DONE);
            if (state_d != state_q) begin
                bit_cnt_q <= '0;
            end else if ((state_q == TBL_SKIP) || (state_q == TBL_STORE)) begin
                bit_cnt_q <= bit_cnt_q + CNT_W'(1);
            end
            if (load) offset_q <= n_id_i[1:0];
        end
    end

    // pairs are written on every odd bit, once both halves are known
    always_ff @(posedge clk_i) begin
        if (state_q == TBL_STORE) begin
            if (!bit_cnt_q[0]) begin
                even_bits_q <= gen_bits;
            end else begin
                table_q[bit_cnt_q[8:1]] <= store_vec;
            end
        end
    end

    assign dmrs_vec_o     = table_q[pilot_idx_i];
    assign pilot_offset_o = offset_q;
    assign n_id_ready_o   = n_id_ready_q;
    assign dmrs_ready_o   = (state_q == TBL_DONE);

endmodule

// File: hw/ibar_correlator.sv
`timescale 1ns/100ps

`include "pbch_params.svh"

module ibar_correlator
    import pbch_pkg::*;
(
    input  logic                                    clk_i,
    input  logic                                    reset_ni,
    input  iq_sample_t                              sym_data_i,
    input  logic                                    sym_first_i,
    input  logic                                    sym_valid_i,
    output logic                                    sym_ready_o,
    input  logic                                    dmrs_ready_i,
    input  logic [1:0]                              pilot_offset_i,
    input  dmrs_vec_t                               dmrs_vec_i,
    output logic [$clog2(`PBCH_PILOTS_PER_SYM)-1:0] pilot_idx_o,
    output corr_sums_t                              sums_plain_o,
    output corr_sums_t                              sums_rot_o,
    output logic                                    sums_valid_o,
    input  logic                                    sums_ready_i
);

    localparam int SC_W  = $clog2(`PBCH_SC_PER_SYM);
    localparam int PIL_W = $clog2(`PBCH_PILOTS_PER_SYM);
    localparam corr_sum_t STEP_POS = 2;
    localparam corr_sum_t STEP_NEG = -2;

    typedef enum logic [1:0] {
        COR_IDLE,
        COR_RUN,
        COR_HOLD
    } cor_state_e;

    cor_state_e        state_q;
    logic [SC_W-1:0]   sc_cnt_q;
    logic [PIL_W-1:0]  pilot_cnt_q;
    corr_sums_t        plain_q;
    corr_sums_t        rot_q;
    corr_sums_t        step_plain;
    corr_sums_t        step_rot;
    logic [1:0]        demod_plain;
    logic [1:0]        demod_rot;
    logic              is_pilot;
    logic              last_sc;
    logic              take;

    // +1 per agreeing bit and -1 per differing bit
    function automatic corr_sum_t corr_step(input dmrs_pair_t ref_pair, input logic [1:0] demod);
        logic [1:0] agree;
        agree = ~(ref_pair ^ demod);
        case (agree)
            2'b11:   return STEP_POS;
            2'b00:   return STEP_NEG;
            default: return '0;
        endcase
    endfunction

    assign sym_ready_o = dmrs_ready_i && (state_q != COR_HOLD);

    // while idle only a sample flagged as first opens a symbol
    assign take    = sym_valid_i && sym_ready_o && ((state_q == COR_RUN) || sym_first_i);
    assign last_sc = (sc_cnt_q == SC_W'(`PBCH_SC_PER_SYM - 1));

    // sc_cnt_q is zero while idle, so the first sample is subcarrier 0
    assign is_pilot = (sc_cnt_q[1:0] == pilot_offset_i);

    // hard QPSK decision, a negative component maps to bit 1
    assign demod_plain = {sym_data_i.re[`PBCH_IQ_W-1], sym_data_i.im[`PBCH_IQ_W-1]};
    // the same decision after rotating the sample by 90 degrees
    assign demod_rot   = {~sym_data_i.im[`PBCH_IQ_W-1], sym_data_i.re[`PBCH_IQ_W-1]};

    always_comb begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            step_plain[i] = is_pilot ? corr_step(dmrs_vec_i[i], demod_plain) : '0;
            step_rot[i]   = is_pilot ? corr_step(dmrs_vec_i[i], demod_rot) : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q     <= COR_IDLE;
            sc_cnt_q    <= '0;
            pilot_cnt_q <= '0;
        end else if (take) begin
            if (last_sc) begin
                sc_cnt_q    <= '0;
                pilot_cnt_q <= '0;
                state_q     <= COR_HOLD;
            end else begin
                sc_cnt_q    <= sc_cnt_q + SC_W'(1);
                pilot_cnt_q <= pilot_cnt_q + PIL_W'(is_pilot);
                state_q     <= COR_RUN;
            end
        end else if ((state_q == COR_HOLD) && sums_ready_i) begin
            state_q <= COR_IDLE;
        end
    end

    // the opening sample of a symbol replaces the old sums
    always_ff @(posedge clk_i) begin
        if (take) begin
            for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                plain_q[i] <= (state_q == COR_IDLE) ? step_plain[i] : plain_q[i] + step_plain[i];
                rot_q[i]   <= (state_q == COR_IDLE) ? step_rot[i] : rot_q[i] + step_rot[i];
            end
        end
    end

    assign pilot_idx_o  = pilot_cnt_q;
    assign sums_plain_o = plain_q;
    assign sums_rot_o   = rot_q;
    assign sums_valid_o = (state_q == COR_HOLD);

endmodule

// File: hw/ibar_decider.sv
`timescale 1ns/100ps

`include "pbch_params.svh"

module ibar_decider
    import pbch_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_ni,
    input  corr_sums_t   sums_plain_i,
    input  corr_sums_t   sums_rot_i,
    input  logic         sums_valid_i,
    output logic         sums_ready_o,
    output ibar_result_t result_o,
    output logic         result_valid_o,
    input  logic         result_ready_i
);

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_SCAN,
        DEC_OUT
    } dec_state_e;

    dec_state_e state_q;
    logic [2:0] idx_q;
    logic [2:0] best_idx_q;
    logic [6:0] best_metric_q;
    logic [6:0] metric_plain;
    logic [6:0] metric_rot;
    logic [6:0] metric;

    // sums stay within +-120, so the magnitude fits in seven bits
    function automatic logic [6:0] sum_abs(input corr_sum_t value);
        corr_sum_t neg;
        neg = -value;
        return value[`PBCH_CORR_W-1] ? neg[6:0] : value[6:0];
    endfunction

    assign metric_plain = sum_abs(sums_plain_i[idx_q]);
    assign metric_rot   = sum_abs(sums_rot_i[idx_q]);
    assign metric       = (metric_rot > metric_plain) ? metric_rot : metric_plain;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= DEC_IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                DEC_IDLE: begin
                    idx_q <= '0;
                    if (sums_valid_i) state_q <= DEC_SCAN;
                end
                DEC_SCAN: begin
                    idx_q <= idx_q + 3'd1;
                    if (idx_q == 3'(`PBCH_NUM_IBAR - 1)) state_q <= DEC_OUT;
                end
                DEC_OUT: begin
                    if (result_ready_i) state_q <= DEC_IDLE;
                end
                default: state_q <= DEC_IDLE;
            endcase
        end
    end

    // only a strictly larger metric replaces the best, so ties keep the lower index
    always_ff @(posedge clk_i) begin
        if (state_q == DEC_IDLE) begin
            best_idx_q    <= '0;
            best_metric_q <= '0;
        end else if ((state_q == DEC_SCAN) && (metric > best_metric_q)) begin
            best_idx_q    <= idx_q;
            best_metric_q <= metric;
        end
    end

    // the correlator keeps its sums until the result has been taken
    assign sums_ready_o   = (state_q == DEC_OUT) && result_ready_i;
    assign result_valid_o = (state_q == DEC_OUT);
    assign result_o.ibar  = best_idx_q;
    assign result_o.peak  = best_metric_q;

endmodule

// File: hw/pbch_dmrs_detector.sv
`timescale 1ns/100ps

`include "pbch_params.svh"

module pbch_dmrs_detector
    import pbch_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_ni,
    input  logic [`PBCH_NID_W-1:0] n_id_i,
    input  logic                   n_id_valid_i,
    output logic                   n_id_ready_o,
    input  iq_sample_t             sym_data_i,
    input  logic                   sym_first_i,
    input  logic                   sym_valid_i,
    output logic                   sym_ready_o,
    output logic                   dmrs_ready_o,
    output ibar_result_t           result_o,
    output logic                   result_valid_o,
    input  logic                   result_ready_i
);

    logic [$clog2(`PBCH_PILOTS_PER_SYM)-1:0] pilot_idx;
    dmrs_vec_t                               dmrs_vec;
    logic [1:0]                              pilot_offset;
    corr_sums_t                              sums_plain;
    corr_sums_t                              sums_rot;
    logic                                    sums_valid;
    logic                                    sums_ready;

    dmrs_table table_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .n_id_ready_o   (n_id_ready_o),
        .pilot_idx_i    (pilot_idx),
        .dmrs_vec_o     (dmrs_vec),
        .pilot_offset_o (pilot_offset),
        .dmrs_ready_o   (dmrs_ready_o)
    );

    ibar_correlator correlator_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sym_data_i     (sym_data_i),
        .sym_first_i    (sym_first_i),
        .sym_valid_i    (sym_valid_i),
        .sym_ready_o    (sym_ready_o),
        .dmrs_ready_i   (dmrs_ready_o),
        .pilot_offset_i (pilot_offset),
        .dmrs_vec_i     (dmrs_vec),
        .pilot_idx_o    (pilot_idx),
        .sums_plain_o   (sums_plain),
        .sums_rot_o     (sums_rot),
        .sums_valid_o   (sums_valid),
        .sums_ready_i   (sums_ready)
    );

    ibar_decider decider_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sums_plain_i   (sums_plain),
        .sums_rot_i     (sums_rot),
        .sums_valid_i   (sums_valid),
        .sums_ready_o   (sums_ready),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i)
    );

endmodule

// File: bench/pbch_assertions.sv
`timescale 1ns/100ps

module pbch_assertions
    import pbch_pkg::*;
(
    input logic         clk_i,
    input logic         reset_ni,
    input logic         n_id_valid_i,
    input logic         n_id_ready_i,
    input logic         sym_ready_i,
    input logic         dmrs_ready_i,
    input ibar_result_t result_i,
    input logic         result_valid_i,
    input logic         result_ready_i
);

    logic accepted_q;
    // number of property violations seen so far
    int   failures = 0;

    // once an N_id is taken the table never returns to idle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            accepted_q <= 1'b0;
        end else if (n_id_valid_i && n_id_ready_i) begin
            accepted_q <= 1'b1;
        end
    end

    sym_ready_needs_table: assert property (@(posedge clk_i) disable iff (!reset_ni)
        sym_ready_i |-> dmrs_ready_i)
        else begin
            $error("sym_ready_o is high while the DMRS table is incomplete");
            failures++;
        end

    result_held: assert property (@(posedge clk_i) disable iff (!reset_ni)
        result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_i))
        else begin
            $error("result changed or dropped before it was accepted");
            failures++;
        end

    n_id_blocked: assert property (@(posedge clk_i) disable iff (!reset_ni)
        accepted_q && !dmrs_ready_i |-> !n_id_ready_i)
        else begin
            $error("n_id_ready_o is high while the table is being built");
            failures++;
        end

endmodule

// File: bench/pbch_tb.sv
`timescale 1ns/100ps

`include "pbch_params.svh"

module pbch_tb
    import pbch_pkg::*;
();

    localparam int GOLD_LEN = `PBCH_GOLD_NC + 2 * `PBCH_DMRS_LEN;
    localparam int LIMIT = 4000;
    localparam int MODE_PLAIN = 0;
    localparam int MODE_ROT = 1;
    localparam int MODE_INV = 2;
    localparam int SEL_NID_READY = 0;
    localparam int SEL_DMRS_READY = 1;
    localparam int SEL_SYM_READY = 2;
    localparam int SEL_RESULT = 3;

    logic                   clk_i;
    logic                   reset_ni;
    logic [`PBCH_NID_W-1:0] n_id_i;
    logic                   n_id_valid_i;
    logic                   n_id_ready_o;
    iq_sample_t             sym_data_i;
    logic                   sym_first_i;
    logic                   sym_valid_i;
    logic                   sym_ready_o;
    logic                   dmrs_ready_o;
    ibar_result_t           result_o;
    logic                   result_valid_o;
    logic                   result_ready_i;

    integer       seed;
    int           errors;
    int           tests_run;
    int           results_seen;
    bit           timed_out;
    ibar_result_t exp_q[$];
    string        name_q[$];

    pbch_dmrs_detector dut_i (.*);

    bind pbch_dmrs_detector pbch_assertions assertions_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_valid_i   (n_id_valid_i),
        .n_id_ready_i   (n_id_ready_o),
        .sym_ready_i    (sym_ready_o),
        .dmrs_ready_i   (dmrs_ready_o),
        .result_i       (result_o),
        .result_valid_i (result_valid_o),
        .result_ready_i (result_ready_i)
    );

    always #2 clk_i = ~clk_i;

    // Gold sequence built directly from x1, x2 and c_init, pair m is {c(2m), c(2m+1)}
    function automatic dmrs_pair_t ref_dmrs_pair(input int n_id, input int ibar, input int m);
        bit x1 [GOLD_LEN];
        bit x2 [GOLD_LEN];
        int c_init;
        int base;
        c_init = 2048 * (ibar + 1) * (n_id / 4 + 1) + 64 * (ibar + 1) + n_id % 4;
        for (int n = 0; n < `PBCH_GOLD_N; n++) begin
            x1[n] = (n == 0);
            x2[n] = c_init[n];
        end
        for (int n = `PBCH_GOLD_N; n < GOLD_LEN; n++) begin
            x1[n] = x1[n-28] ^ x1[n-31];
            x2[n] = x2[n-28] ^ x2[n-29] ^ x2[n-30] ^ x2[n-31];
        end
        base = `PBCH_GOLD_NC + 2 * m;
        return {x1[base] ^ x2[base], x1[base+1] ^ x2[base+1]};
    endfunction

    function automatic logic level_of(input int sel);
        case (sel)
            SEL_NID_READY:  return n_id_ready_o;
            SEL_DMRS_READY: return dmrs_ready_o;
            SEL_SYM_READY:  return sym_ready_o;
            default:        return result_valid_o;
        endcase
    endfunction

    // polls at the falling edge and leaves 1 ns after the following rising edge
    task automatic wait_high(input int sel, input string what);
        int cycles;
        if (timed_out) return;
        cycles = 0;
        @(negedge clk_i);
        while (!level_of(sel) && !timed_out) begin
            if (cycles == LIMIT) begin
                $display("timeout: %s never went high", what);
                timed_out = 1'b1;
            end else begin
                cycles++;
                @(negedge clk_i);
            end
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic wait_results(input int target, input string what);
        int cycles;
        cycles = 0;
        while ((results_seen < target) && !timed_out) begin
            if (cycles == LIMIT) begin
                $display("timeout: no result arrived for %s", what);
                timed_out = 1'b1;
            end else begin
                cycles++;
                @(posedge clk_i);
                #1;
            end
        end
    endtask

    task automatic load_n_id(input int n_id);
        if (timed_out) return;
        n_id_i = n_id[`PBCH_NID_W-1:0];
        n_id_valid_i = 1'b1;
        wait_high(SEL_NID_READY, "n_id_ready_o");
        n_id_valid_i = 1'b0;
        wait_high(SEL_DMRS_READY, "dmrs_ready_o after a new N_id");
    endtask

    task automatic send_sample(input iq_sample_t smp, input logic first);
        if (timed_out) return;
        sym_data_i = smp;
        sym_first_i = first;
        sym_valid_i = 1'b1;
        wait_high(SEL_SYM_READY, "sym_ready_o");
        sym_valid_i = 1'b0;
    endtask

    // pilot signs follow the reference pair, other subcarriers carry noise
    task automatic send_symbol(input int n_id, input int ibar, input int mode);
        iq_sample_t            smp;
        dmrs_pair_t            pair;
        logic                  neg_re;
        logic                  neg_im;
        logic signed [`PBCH_IQ_W-1:0] mag_re;
        logic signed [`PBCH_IQ_W-1:0] mag_im;
        for (int k = 0; k < `PBCH_SC_PER_SYM; k++) begin
            if (k % 4 == n_id % 4) begin
                pair = ref_dmrs_pair(n_id, ibar, k / 4);
                case (mode)
                    MODE_ROT: begin
                        neg_re = pair[0];
                        neg_im = !pair[1];
                    end
                    MODE_INV: begin
                        neg_re = !pair[1];
                        neg_im = !pair[0];
                    end
                    default: begin
                        neg_re = pair[1];
                        neg_im = pair[0];
                    end
                endcase
                mag_re = 16'(($random(seed) & 16'h3fff) + 1);
                mag_im = 16'(($random(seed) & 16'h3fff) + 1);
                smp.re = neg_re ? -mag_re : mag_re;
                smp.im = neg_im ? -mag_im : mag_im;
            end else begin
                smp = $random(seed);
            end
            send_sample(smp, k == 0);
        end
        sym_first_i = 1'b0;
    endtask

    task automatic expect_result(input string name, input int ibar);
        ibar_result_t expected;
        expected.ibar = 3'(ibar);
        expected.peak = 7'd120;
        exp_q.push_back(expected);
        name_q.push_back(name);
    endtask

    task automatic run_symbol(input string name, input int n_id, input int ibar, input int mode);
        int target;
        if (timed_out) return;
        target = results_seen + 1;
        expect_result(name, ibar);
        send_symbol(n_id, ibar, mode);
        wait_results(target, name);
    endtask

    // the result must sit still and the input must stay closed while ready is low
    task automatic check_backpressure();
        ibar_result_t held;
        int           target;
        int           errors_before;
        if (timed_out) return;
        target = results_seen + 1;
        result_ready_i = 1'b0;
        expect_result("backpressure nid397 ibar3", 3);
        send_symbol(397, 3, MODE_PLAIN);
        wait_high(SEL_RESULT, "result_valid_o under backpressure");
        held = result_o;
        errors_before = errors;
        repeat (30) begin
            @(negedge clk_i);
            assert (result_valid_o && (result_o == held)) else begin
                $display("MISMATCH backpressure hold expected %h actual %h", held, result_o);
                errors++;
            end
            assert (!sym_ready_o) else begin
                $display("sym_ready_o went high while the result was held back");
                errors++;
            end
        end
        tests_run++;
        $display("test backpressure hold: %s", (errors == errors_before) ? "pass" : "fail");
        @(posedge clk_i);
        #1;
        result_ready_i = 1'b1;
        wait_results(target, "backpressure nid397 ibar3");
        run_symbol("after backpressure ibar4", 397, 4, MODE_PLAIN);
    endtask

    always @(negedge clk_i) begin : compare_results
        ibar_result_t expected;
        string        name;
        int           errors_before;
        if (reset_ni && result_valid_o && result_ready_i) begin
            assert (exp_q.size() > 0) else begin
                $display("a result arrived while no symbol was pending");
                errors++;
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                name = name_q.pop_front();
                errors_before = errors;
                assert (result_o == expected) else begin
                    $display("MISMATCH %s expected ibar %0d peak %0d actual ibar %0d peak %0d",
                             name, expected.ibar, expected.peak, result_o.ibar, result_o.peak);
                    errors++;
                end
                tests_run++;
                $display("test %s: %s", name, (errors == errors_before) ? "pass" : "fail");
            end
            results_seen++;
        end
    end

    initial begin
        seed = 32'h1c0f;
        errors = 0;
        tests_run = 0;
        results_seen = 0;
        timed_out = 1'b0;
        clk_i = 1'b0;
        reset_ni = 1'b0;
        n_id_i = '0;
        n_id_valid_i = 1'b0;
        sym_data_i = '0;
        sym_first_i = 1'b0;
        sym_valid_i = 1'b0;
        result_ready_i = 1'b1;
        repeat (16) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;

        load_n_id(0);
        run_symbol("nid0 ibar5 plain", 0, 5, MODE_PLAIN);
        load_n_id(1007);
        run_symbol("nid1007 ibar5 plain", 1007, 5, MODE_PLAIN);
        run_symbol("nid1007 ibar2 rotated", 1007, 2, MODE_ROT);
        load_n_id(397);
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            run_symbol($sformatf("nid397 ibar%0d plain", i), 397, i, MODE_PLAIN);
        end
        check_backpressure();
        run_symbol("nid397 ibar6 inverted", 397, 6, MODE_INV);

        // violations of the bound handshake properties count as errors too
        errors += dut_i.assertions_i.failures;
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (timed_out || (errors != 0)) begin
            $display("CHECKS FAILED");
        end else begin
            $display("ALL CHECKS PASSED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+common
common/pbch_pkg.sv
dmrs_gen/gold_seq_gen.sv
dmrs_gen/dmrs_table.sv
hw/ibar_correlator.sv
hw/ibar_decider.sv
hw/pbch_dmrs_detector.sv
bench/pbch_assertions.sv
bench/pbch_tb.sv

// File: Bender.yml
package:
  name: pbch_dmrs_detector

sources:
  - include_dirs:
      - common
    files:
      - common/pbch_pkg.sv
      - dmrs_gen/gold_seq_gen.sv
      - dmrs_gen/dmrs_table.sv
      - hw/ibar_correlator.sv
      - hw/ibar_decider.sv
      - hw/pbch_dmrs_detector.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/pbch_assertions.sv
      - bench/pbch_tb.sv
